//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module cpuTb \
    -Mdir obj_dir -f verilog.f

simOutput=$(./obj_dir/VcpuTb)
echo "$simOutput"

if echo "$simOutput" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi

//--- source/alu.sv
`default_nettype none

module alu (
    input wire [isaPkg::WordSize-1:0] operandA,
    input wire [isaPkg::WordSize-1:0] operandB,
    input wire [isaPkg::WordSize-1:0] imm,
    input wire [3:0] opcode,
    input wire [5:0] func,
    input wire isAlu,
    output logic [isaPkg::WordSize-1:0] result,
    output logic branchTaken
);
    logic [3:0] aluOp;
    logic [isaPkg::WordSize-1:0] opB;

    // ORI takes a zero-extended immediate
    assign opB = (opcode == isaPkg::OpOri) ? {{(isaPkg::WordSize - 8){1'b0}}, imm[7:0]}
                                           : operandB;

    always_comb begin
        aluOp = pipePkg::AluAdd;
        if (isAlu && opcode == isaPkg::OpOri) begin
            aluOp = pipePkg::AluOrr;
        end else if (isAlu && opcode == isaPkg::OpRtype) begin
            case (func)
                isaPkg::FnAdd: aluOp = pipePkg::AluAdd;
                isaPkg::FnSub: aluOp = pipePkg::AluSub;
                isaPkg::FnAnd: aluOp = pipePkg::AluAnd;
                isaPkg::FnOrr: aluOp = pipePkg::AluOrr;
                isaPkg::FnNot: aluOp = pipePkg::AluNot;
                isaPkg::FnTcp: aluOp = pipePkg::AluTcp;
                isaPkg::FnShl: aluOp = pipePkg::AluShl;
                isaPkg::FnShr: aluOp = pipePkg::AluShr;
                default: aluOp = pipePkg::AluPassA;
            endcase
        end
    end

    always_comb begin
        case (aluOp)
            pipePkg::AluSub: result = operandA - opB;
            pipePkg::AluAnd: result = operandA & opB;
            pipePkg::AluOrr: result = operandA | opB;
            pipePkg::AluNot: result = ~operandA;
            pipePkg::AluTcp: result = ~operandA + 1'b1;
            pipePkg::AluShl: result = {operandA[isaPkg::WordSize-2:0], 1'b0};
            // Arithmetic shift
            pipePkg::AluShr: result = {operandA[isaPkg::WordSize-1], operandA[isaPkg::WordSize-1:1]};
            pipePkg::AluPassA: result = operandA;
            default: result = operandA + opB;
        endcase
        if (isAlu && opcode == isaPkg::OpLhi) begin
            result = {imm[7:0], 8'b0};
        end
    end

    // Signed tests on rs for BGZ and BLZ
    always_comb begin
        case (opcode)
            isaPkg::OpBne: branchTaken = operandA != operandB;
            isaPkg::OpBeq: branchTaken = operandA == operandB;
            isaPkg::OpBgz: branchTaken = !operandA[isaPkg::WordSize-1] && (|operandA);
            isaPkg::OpBlz: branchTaken = operandA[isaPkg::WordSize-1];
            default: branchTaken = 1'b0;
        endcase
    end
endmodule

`default_nettype wire

//--- source/controlUnit.sv
`default_nettype none

module controlUnit (
    input wire [3:0] opcode,
    input wire [5:0] func,
    output logic [pipePkg::CtrlWidth-1:0] ctrl
);
    always_comb begin
        ctrl = '0;
        case (opcode)
            isaPkg::OpBne, isaPkg::OpBeq, isaPkg::OpBgz, isaPkg::OpBlz: begin
                ctrl[pipePkg::CtlIsBranch] = 1'b1;
            end
            isaPkg::OpAdi, isaPkg::OpOri, isaPkg::OpLhi: begin
                ctrl[pipePkg::CtlRegWrite] = 1'b1;
                ctrl[pipePkg::CtlAluSrc] = 1'b1;
                ctrl[pipePkg::CtlIsAlu] = 1'b1;
            end
            isaPkg::OpLwd: begin
                ctrl[pipePkg::CtlMemRead] = 1'b1;
                ctrl[pipePkg::CtlMemToReg] = 1'b1;
                ctrl[pipePkg::CtlRegWrite] = 1'b1;
                ctrl[pipePkg::CtlAluSrc] = 1'b1;
            end
            isaPkg::OpSwd: begin
                ctrl[pipePkg::CtlMemWrite] = 1'b1;
                ctrl[pipePkg::CtlAluSrc] = 1'b1;
            end
            isaPkg::OpJmp: begin
                ctrl[pipePkg::CtlIsJumpI] = 1'b1;
            end
            isaPkg::OpJal: begin
                ctrl[pipePkg::CtlIsJumpI] = 1'b1;
                ctrl[pipePkg::CtlIsLink] = 1'b1;
                ctrl[pipePkg::CtlRegWrite] = 1'b1;
            end
            isaPkg::OpRtype: begin
                case (func)
                    isaPkg::FnAdd, isaPkg::FnSub, isaPkg::FnAnd, isaPkg::FnOrr,
                    isaPkg::FnNot, isaPkg::FnTcp, isaPkg::FnShl, isaPkg::FnShr: begin
                        ctrl[pipePkg::CtlRegWrite] = 1'b1;
                        ctrl[pipePkg::CtlIsAlu] = 1'b1;
                    end
                    isaPkg::FnJpr: begin
                        ctrl[pipePkg::CtlIsJumpR] = 1'b1;
                    end
                    isaPkg::FnJrl: begin
                        ctrl[pipePkg::CtlIsJumpR] = 1'b1;
                        ctrl[pipePkg::CtlIsLink] = 1'b1;
                        ctrl[pipePkg::CtlRegWrite] = 1'b1;
                    end
                    // WWD passes rs through the ALU
                    isaPkg::FnWwd: begin
                        ctrl[pipePkg::CtlWwd] = 1'b1;
                        ctrl[pipePkg::CtlIsAlu] = 1'b1;
                    end
                    isaPkg::FnHlt: begin
                        ctrl[pipePkg::CtlHalt] = 1'b1;
                    end
                    default: begin
                        ctrl = '0;
                    end
                endcase
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end
endmodule

`default_nettype wire

//--- source/cpuTop.sv
`default_nettype none

module cpuTop (
    input wire Clk,
    input wire rst,
    output wire [isaPkg::WordSize-1:0] instrAddr,
    output wire instrRead,
    input wire [isaPkg::WordSize-1:0] instrData,
    output wire [isaPkg::WordSize-1:0] dataAddr,
    output wire [isaPkg::WordSize-1:0] dataWdata,
    output wire dataRead,
    output wire dataWrite,
    input wire [isaPkg::WordSize-1:0] dataRdata,
    output wire halted,
    output wire [isaPkg::WordSize-1:0] retiredCount,
    output wire [isaPkg::WordSize-1:0] outputPort
);
    wire [3:0] opcode;
    wire [5:0] func;
    wire [pipePkg::CtrlWidth-1:0] ctrl;

    controlUnit control (
        .opcode(opcode), .func(func), .ctrl(ctrl)
    );

    datapath core (
        .Clk(Clk), .rst(rst), .ctrl(ctrl), .opcode(opcode), .func(func),
        .instrAddr(instrAddr), .instrRead(instrRead), .instrData(instrData),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataRead(dataRead),
        .dataWrite(dataWrite), .dataRdata(dataRdata), .halted(halted),
        .retiredCount(retiredCount), .outputPort(outputPort)
    );
endmodule

`default_nettype wire

//--- source/datapath.sv
`default_nettype none

module datapath (
    input wire Clk,
    input wire rst,
    input wire [pipePkg::CtrlWidth-1:0] ctrl,
    output logic [3:0] opcode,
    output logic [5:0] func,
    output logic [isaPkg::WordSize-1:0] instrAddr,
    output logic instrRead,
    input wire [isaPkg::WordSize-1:0] instrData,
    output logic [isaPkg::WordSize-1:0] dataAddr,
    output logic [isaPkg::WordSize-1:0] dataWdata,
    output logic dataRead,
    output logic dataWrite,
    input wire [isaPkg::WordSize-1:0] dataRdata,
    output logic halted,
    output logic [isaPkg::WordSize-1:0] retiredCount,
    output logic [isaPkg::WordSize-1:0] outputPort
);
    logic [isaPkg::WordSize-1:0] pc, pcPlus1;
    logic haltPending, fetchStop, stall, idJump, exRedirect, branchTaken;
    logic ifIdBubble, idExBubble, exMemBubble, memWbBubble;
    logic [pipePkg::IfIdWidth-1:0] ifIdIn, ifIdOut;
    logic [pipePkg::IdExWidth-1:0] idExIn, idExOut;
    logic [pipePkg::ExMemWidth-1:0] exMemIn, exMemOut;
    logic [pipePkg::MemWbWidth-1:0] memWbIn, memWbOut;

    logic [isaPkg::WordSize-1:0] idPcPlus1, idInstr, idImm, idTarget, regA, regB;
    logic [isaPkg::RegAddrWidth-1:0] idRs, idRt, idRd;
    logic [pipePkg::CtrlWidth-1:0] idCtrl, exCtrlRaw, exCtrl, memCtrlRaw, memCtrl;
    logic [pipePkg::CtrlWidth-1:0] wbCtrlRaw, wbCtrl;
    logic idUseRs, idUseRt;

    logic [isaPkg::WordSize-1:0] exPcPlus1, exRegA, exRegB, exImm, fwdA, fwdB, aluB;
    logic [isaPkg::WordSize-1:0] aluResult, exResult, exTarget;
    logic [isaPkg::RegAddrWidth-1:0] exRs, exRt, exRd, memRd, wbRd;
    logic [3:0] exOpcode;
    logic [5:0] exFunc;
    logic [1:0] forwardA, forwardB;
    logic [isaPkg::WordSize-1:0] memResult, memStore, wbResult, wbLoad, wbValue;

    // IF
    assign pcPlus1 = pc + 1'b1;
    assign instrAddr = pc;
    assign instrRead = !halted;
    assign ifIdIn = {pcPlus1, instrData};

    stageLatch #(.PayloadType(logic [pipePkg::IfIdWidth-1:0])) ifId (
        .Clk(Clk), .rst(rst), .hold(stall), .flush(exRedirect || idJump || fetchStop),
        .inBubble(1'b0), .inPayload(ifIdIn), .bubble(ifIdBubble), .payload(ifIdOut)
    );

    // ID
    assign {idPcPlus1, idInstr} = ifIdOut;
    assign opcode = idInstr[isaPkg::OpcodeHi:isaPkg::OpcodeLo];
    assign func = idInstr[isaPkg::FuncHi:isaPkg::FuncLo];
    assign idRs = idInstr[isaPkg::RsHi:isaPkg::RsLo];
    assign idRt = idInstr[isaPkg::RtHi:isaPkg::RtLo];
    assign idImm = {{(isaPkg::WordSize - 8){idInstr[isaPkg::ImmHi]}},
                    idInstr[isaPkg::ImmHi:isaPkg::ImmLo]};
    assign idTarget = {idPcPlus1[isaPkg::WordSize-1:isaPkg::TargetHi+1],
                       idInstr[isaPkg::TargetHi:isaPkg::TargetLo]};
    assign idCtrl = ifIdBubble ? '0 : ctrl;
    assign idRd = idCtrl[pipePkg::CtlIsLink] ? isaPkg::LinkReg
                : (opcode == isaPkg::OpRtype) ? idInstr[isaPkg::RdHi:isaPkg::RdLo] : idRt;
    assign idUseRs = (|idCtrl) && !idCtrl[pipePkg::CtlIsJumpI] && !idCtrl[pipePkg::CtlHalt]
                     && opcode != isaPkg::OpLhi;
    assign idUseRt = idCtrl[pipePkg::CtlMemWrite]
                     || (idCtrl[pipePkg::CtlIsBranch] && opcode inside {isaPkg::OpBne, isaPkg::OpBeq})
                     || (idCtrl[pipePkg::CtlIsAlu] && opcode == isaPkg::OpRtype
                         && func inside {isaPkg::FnAdd, isaPkg::FnSub, isaPkg::FnAnd, isaPkg::FnOrr});
    assign idJump = idCtrl[pipePkg::CtlIsJumpI];
    // Nothing younger than HLT is fetched
    assign fetchStop = haltPending || idCtrl[pipePkg::CtlHalt];

    registerFile regFile (
        .Clk(Clk), .rst(rst), .readAddrA(idRs), .readAddrB(idRt), .writeAddr(wbRd),
        .writeData(wbValue), .writeEnable(wbCtrl[pipePkg::CtlRegWrite]),
        .readDataA(regA), .readDataB(regB)
    );

    hazardUnit hazard (
        .idRs(idRs), .idRt(idRt), .idUseRs(idUseRs), .idUseRt(idUseRt),
        .exRs(exRs), .exRt(exRt), .exRd(exRd), .exMemRead(exCtrl[pipePkg::CtlMemRead]),
        .memRd(memRd), .memRegWrite(memCtrl[pipePkg::CtlRegWrite]),
        .wbRd(wbRd), .wbRegWrite(wbCtrl[pipePkg::CtlRegWrite]),
        .forwardA(forwardA), .forwardB(forwardB), .stall(stall)
    );

    assign idExIn = {idCtrl, idPcPlus1, regA, regB, idRs, idRt, idRd, opcode, func, idImm};

    stageLatch #(.PayloadType(logic [pipePkg::IdExWidth-1:0])) idEx (
        .Clk(Clk), .rst(rst), .hold(1'b0), .flush(exRedirect || stall),
        .inBubble(ifIdBubble), .inPayload(idExIn), .bubble(idExBubble), .payload(idExOut)
    );

    // EX
    assign {exCtrlRaw, exPcPlus1, exRegA, exRegB, exRs, exRt, exRd, exOpcode, exFunc,
            exImm} = idExOut;
    assign exCtrl = idExBubble ? '0 : exCtrlRaw;
    assign fwdA = (forwardA == pipePkg::FwdMem) ? memResult
                : (forwardA == pipePkg::FwdWb) ? wbValue : exRegA;
    assign fwdB = (forwardB == pipePkg::FwdMem) ? memResult
                : (forwardB == pipePkg::FwdWb) ? wbValue : exRegB;
    assign aluB = exCtrl[pipePkg::CtlAluSrc] ? exImm : fwdB;

    alu exAlu (
        .operandA(fwdA), .operandB(aluB), .imm(exImm), .opcode(exOpcode), .func(exFunc),
        .isAlu(exCtrl[pipePkg::CtlIsAlu]), .result(aluResult), .branchTaken(branchTaken)
    );

    assign exResult = exCtrl[pipePkg::CtlIsLink] ? exPcPlus1 : aluResult;
    assign exRedirect = (exCtrl[pipePkg::CtlIsBranch] && branchTaken)
                        || exCtrl[pipePkg::CtlIsJumpR];
    assign exTarget = exCtrl[pipePkg::CtlIsJumpR] ? fwdA : exPcPlus1 + exImm;
    assign exMemIn = {exCtrl, exResult, fwdB, exRd};

    stageLatch #(.PayloadType(logic [pipePkg::ExMemWidth-1:0])) exMem (
        .Clk(Clk), .rst(rst), .hold(1'b0), .flush(1'b0),
        .inBubble(idExBubble), .inPayload(exMemIn), .bubble(exMemBubble), .payload(exMemOut)
    );

    // MEM
    assign {memCtrlRaw, memResult, memStore, memRd} = exMemOut;
    assign memCtrl = exMemBubble ? '0 : memCtrlRaw;
    assign dataAddr = memResult;
    assign dataWdata = memStore;
    assign dataRead = memCtrl[pipePkg::CtlMemRead];
    assign dataWrite = memCtrl[pipePkg::CtlMemWrite];
    assign memWbIn = {memCtrl, memResult, dataRdata, memRd};

    stageLatch #(.PayloadType(logic [pipePkg::MemWbWidth-1:0])) memWb (
        .Clk(Clk), .rst(rst), .hold(1'b0), .flush(1'b0),
        .inBubble(exMemBubble), .inPayload(memWbIn), .bubble(memWbBubble), .payload(memWbOut)
    );

    // WB
    assign {wbCtrlRaw, wbResult, wbLoad, wbRd} = memWbOut;
    assign wbCtrl = memWbBubble ? '0 : wbCtrlRaw;
    assign wbValue = wbCtrl[pipePkg::CtlMemToReg] ? wbLoad : wbResult;

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= '0;
            haltPending <= 1'b0;
            halted <= 1'b0;
            retiredCount <= '0;
            outputPort <= '0;
        end else begin
            // EX redirect beats ID jump
            if (exRedirect) begin
                pc <= exTarget;
            end else if (!stall && !fetchStop) begin
                pc <= idJump ? idTarget : pcPlus1;
            end
            if (idCtrl[pipePkg::CtlHalt] && !exRedirect) begin
                haltPending <= 1'b1;
            end
            if (wbCtrl[pipePkg::CtlHalt]) begin
                halted <= 1'b1;
            end
            if (!memWbBubble) begin
                retiredCount <= retiredCount + 1'b1;
            end
            if (wbCtrl[pipePkg::CtlWwd]) begin
                outputPort <= wbResult;
            end
        end
    end
endmodule

`default_nettype wire

//--- source/hazardUnit.sv
`default_nettype none

module hazardUnit (
    input wire [isaPkg::RegAddrWidth-1:0] idRs,
    input wire [isaPkg::RegAddrWidth-1:0] idRt,
    input wire idUseRs,
    input wire idUseRt,
    input wire [isaPkg::RegAddrWidth-1:0] exRs,
    input wire [isaPkg::RegAddrWidth-1:0] exRt,
    input wire [isaPkg::RegAddrWidth-1:0] exRd,
    input wire exMemRead,
    input wire [isaPkg::RegAddrWidth-1:0] memRd,
    input wire memRegWrite,
    input wire [isaPkg::RegAddrWidth-1:0] wbRd,
    input wire wbRegWrite,
    output logic [1:0] forwardA,
    output logic [1:0] forwardB,
    output logic stall
);
    // Youngest producer first
    always_comb begin
        forwardA = pipePkg::FwdNone;
        if (memRegWrite && memRd == exRs) begin
            forwardA = pipePkg::FwdMem;
        end else if (wbRegWrite && wbRd == exRs) begin
            forwardA = pipePkg::FwdWb;
        end
    end

    always_comb begin
        forwardB = pipePkg::FwdNone;
        if (memRegWrite && memRd == exRt) begin
            forwardB = pipePkg::FwdMem;
        end else if (wbRegWrite && wbRd == exRt) begin
            forwardB = pipePkg::FwdWb;
        end
    end

    // Load result is not ready before MEM
    assign stall = exMemRead && ((idUseRs && idRs == exRd) || (idUseRt && idRt == exRd));
endmodule

`default_nettype wire

//--- source/isaPkg.sv
`default_nettype none

package isaPkg;
    localparam int WordSize = 16;
    localparam int RegCount = 4;
    localparam int RegAddrWidth = 2;

    localparam logic [3:0] OpBne = 4'd0;
    localparam logic [3:0] OpBeq = 4'd1;
    localparam logic [3:0] OpBgz = 4'd2;
    localparam logic [3:0] OpBlz = 4'd3;
    localparam logic [3:0] OpAdi = 4'd4;
    localparam logic [3:0] OpOri = 4'd5;
    localparam logic [3:0] OpLhi = 4'd6;
    localparam logic [3:0] OpLwd = 4'd7;
    localparam logic [3:0] OpSwd = 4'd8;
    localparam logic [3:0] OpJmp = 4'd9;
    localparam logic [3:0] OpJal = 4'd10;
    localparam logic [3:0] OpRtype = 4'd15;

    localparam logic [5:0] FnAdd = 6'd0;
    localparam logic [5:0] FnSub = 6'd1;
    localparam logic [5:0] FnAnd = 6'd2;
    localparam logic [5:0] FnOrr = 6'd3;
    localparam logic [5:0] FnNot = 6'd4;
    localparam logic [5:0] FnTcp = 6'd5;
    localparam logic [5:0] FnShl = 6'd6;
    localparam logic [5:0] FnShr = 6'd7;
    localparam logic [5:0] FnJpr = 6'd25;
    localparam logic [5:0] FnJrl = 6'd26;
    localparam logic [5:0] FnWwd = 6'd28;
    localparam logic [5:0] FnHlt = 6'd29;

    // Instruction field bounds
    localparam int OpcodeHi = 15;
    localparam int OpcodeLo = 12;
    localparam int RsHi = 11;
    localparam int RsLo = 10;
    localparam int RtHi = 9;
    localparam int RtLo = 8;
    localparam int RdHi = 7;
    localparam int RdLo = 6;
    localparam int FuncHi = 5;
    localparam int FuncLo = 0;
    localparam int ImmHi = 7;
    localparam int ImmLo = 0;
    localparam int TargetHi = 11;
    localparam int TargetLo = 0;

    // Link destination of JAL and JRL
    localparam logic [RegAddrWidth-1:0] LinkReg = 2'd2;
endpackage

`default_nettype wire

//--- source/pipePkg.sv
`default_nettype none

package pipePkg;
    localparam int CtrlWidth = 12;

    localparam int CtlWwd = 0;
    localparam int CtlRegWrite = 1;
    localparam int CtlMemToReg = 2;
    localparam int CtlMemWrite = 3;
    localparam int CtlMemRead = 4;
    localparam int CtlIsBranch = 5;
    localparam int CtlAluSrc = 6;
    localparam int CtlIsAlu = 7;
    localparam int CtlIsJumpR = 8;
    localparam int CtlIsJumpI = 9;
    localparam int CtlIsLink = 10;
    localparam int CtlHalt = 11;

    localparam logic [1:0] FwdNone = 2'd0;
    localparam logic [1:0] FwdMem = 2'd1;
    localparam logic [1:0] FwdWb = 2'd2;

    localparam logic [3:0] AluAdd = 4'd0;
    localparam logic [3:0] AluSub = 4'd1;
    localparam logic [3:0] AluAnd = 4'd2;
    localparam logic [3:0] AluOrr = 4'd3;
    localparam logic [3:0] AluNot = 4'd4;
    localparam logic [3:0] AluTcp = 4'd5;
    localparam logic [3:0] AluShl = 4'd6;
    localparam logic [3:0] AluShr = 4'd7;
    localparam logic [3:0] AluPassA = 4'd8;

    // PC+1 and instruction
    localparam int IfIdWidth = 2 * isaPkg::WordSize;
    // Ctrl, PC+1, two operands, imm, three regs, opcode and func
    localparam int IdExWidth = CtrlWidth + 4 * isaPkg::WordSize
                             + 3 * isaPkg::RegAddrWidth + 10;
    localparam int ExMemWidth = CtrlWidth + 2 * isaPkg::WordSize + isaPkg::RegAddrWidth;
    localparam int MemWbWidth = CtrlWidth + 2 * isaPkg::WordSize + isaPkg::RegAddrWidth;
endpackage

`default_nettype wire

//--- source/registerFile.sv
`default_nettype none

module registerFile (
    input wire Clk,
    input wire rst,
    input wire [isaPkg::RegAddrWidth-1:0] readAddrA,
    input wire [isaPkg::RegAddrWidth-1:0] readAddrB,
    input wire [isaPkg::RegAddrWidth-1:0] writeAddr,
    input wire [isaPkg::WordSize-1:0] writeData,
    input wire writeEnable,
    output logic [isaPkg::WordSize-1:0] readDataA,
    output logic [isaPkg::WordSize-1:0] readDataB
);
    logic [isaPkg::WordSize-1:0] regs [isaPkg::RegCount];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < isaPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Write-through bypass, WB result seen by ID in the same cycle
    assign readDataA = (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];
endmodule

`default_nettype wire

//--- source/stageLatch.sv
`default_nettype none

module stageLatch #(
    parameter type PayloadType = logic
) (
    input wire Clk,
    input wire rst,
    input wire hold,
    input wire flush,
    input wire inBubble,
    input wire PayloadType inPayload,
    output logic bubble,
    output PayloadType payload
);
    always_ff @(posedge Clk) begin
        if (rst || flush) begin
            bubble <= 1'b1;
        end else if (!hold) begin
            bubble <= inBubble;
        end
    end

    // Contents are ignored while bubble is set
    always_ff @(posedge Clk) begin
        if (!hold) begin
            payload <= inPayload;
        end
    end
endmodule

`default_nettype wire

//--- tb/cpuTb.sv
`default_nettype none

module cpuTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TimeoutCycles = 2000;
    localparam int QuietCycles = 10;
    localparam int MemWords = 256;
    localparam int TraceWords = 256;
    localparam logic [7:0] KindInstr = 8'h01;
    localparam logic [7:0] KindOutput = 8'h02;
    localparam logic [7:0] KindData = 8'h03;
    localparam logic [7:0] KindRetired = 8'h04;

    logic Clk;
    logic rst = 1'b1;
    logic [isaPkg::WordSize-1:0] instrAddr;
    logic [isaPkg::WordSize-1:0] instrData;
    logic [isaPkg::WordSize-1:0] dataAddr;
    logic [isaPkg::WordSize-1:0] dataWdata;
    logic [isaPkg::WordSize-1:0] dataRdata;
    logic [isaPkg::WordSize-1:0] retiredCount;
    logic [isaPkg::WordSize-1:0] outputPort;
    logic instrRead;
    logic dataRead;
    logic dataWrite;
    logic halted;

    logic [15:0] instrMem [MemWords];
    logic [15:0] dataMem [MemWords];
    logic [31:0] traceMem [TraceWords];
    logic [15:0] expectedOut [$];
    logic [7:0] expectedAddr [$];
    logic [15:0] expectedData [$];
    logic [15:0] expectedRetired;
    logic [15:0] lastOutput;
    int outputIndex;
    int outputChecks;
    int outputErrors;
    int checkCount;
    int errorCount;

    cpuTop uut (
        .Clk(Clk), .rst(rst), .instrAddr(instrAddr), .instrRead(instrRead),
        .instrData(instrData), .dataAddr(dataAddr), .dataWdata(dataWdata),
        .dataRead(dataRead), .dataWrite(dataWrite), .dataRdata(dataRdata),
        .halted(halted), .retiredCount(retiredCount), .outputPort(outputPort)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // Both memories answer in the same cycle
    assign instrData = instrRead ? instrMem[instrAddr[7:0]] : '0;
    assign dataRdata = dataRead ? dataMem[dataAddr[7:0]] : '0;

    always @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < MemWords; i++) begin
                dataMem[i] <= '0;
            end
        end else if (dataWrite) begin
            dataMem[dataAddr[7:0]] <= dataWdata;
        end
    end

    task automatic loadTrace();
        logic [7:0] kind;
        logic [7:0] addr;
        logic [15:0] value;
        for (int i = 0; i < MemWords; i++) begin
            instrMem[i] = '0;
        end
        for (int i = 0; i < TraceWords; i++) begin
            traceMem[i] = '0;
        end
        expectedRetired = '0;
        $readmemh("tb/program_trace.txt", traceMem);
        for (int i = 0; i < TraceWords; i++) begin
            kind = traceMem[i][31:24];
            addr = traceMem[i][23:16];
            value = traceMem[i][15:0];
            case (kind)
                KindInstr: instrMem[addr] = value;
                KindOutput: expectedOut.push_back(value);
                KindData: begin
                    expectedAddr.push_back(addr);
                    expectedData.push_back(value);
                end
                KindRetired: expectedRetired = value;
                default: begin
                end
            endcase
        end
    endtask

    task automatic checkWord(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
        checkCount++;
        assert (actual == expected) else begin
            $display("FAIL %s: expected 0x%04h, actual 0x%04h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkDataMemory();
        string name;
        for (int i = 0; i < expectedAddr.size(); i++) begin
            name = $sformatf("data memory 0x%02h", expectedAddr[i]);
            checkWord(name, expectedData[i], dataMem[expectedAddr[i]]);
        end
    endtask

    // Every change of the output port must be the next expected value
    always @(negedge Clk) begin
        if (rst) begin
            lastOutput = '0;
            outputIndex = 0;
            outputChecks = 0;
            outputErrors = 0;
        end else if (outputPort != lastOutput) begin
            lastOutput = outputPort;
            outputChecks++;
            assert (outputIndex < expectedOut.size()) else begin
                $display("ERROR: output port changed to 0x%04h after all expected outputs",
                         outputPort);
                outputErrors++;
            end
            if (outputIndex < expectedOut.size()) begin
                assert (outputPort == expectedOut[outputIndex]) else begin
                    $display("FAIL output %0d: expected 0x%04h, actual 0x%04h", outputIndex,
                             expectedOut[outputIndex], outputPort);
                    outputErrors++;
                end
                outputIndex++;
            end
        end
    end

    initial begin
        int cycles;
        checkCount = 0;
        errorCount = 0;
        loadTrace();
        repeat (3) @(posedge Clk);
        rst <= 1'b0;
        @(negedge Clk);
        checkWord("reset instrRead", 16'd1, {15'd0, instrRead});
        checkWord("reset halted", 16'd0, {15'd0, halted});
        checkWord("reset outputPort", 16'd0, outputPort);
        checkWord("reset retiredCount", 16'd0, retiredCount);

        cycles = 0;
        while (!halted && cycles < TimeoutCycles) begin
            @(negedge Clk);
            cycles++;
        end

        if (!halted) begin
            $display("ERROR: the core did not halt within %0d cycles", TimeoutCycles);
            errorCount++;
        end else begin
            checkWord("retired count", expectedRetired, retiredCount);
            checkDataMemory();
            // Nothing may retire or reach the output port once halted
            repeat (QuietCycles) @(negedge Clk);
            checkWord("retired count after halt", expectedRetired, retiredCount);
            checkWord("instrRead after halt", 16'd0, {15'd0, instrRead});
            checkWord("halted after halt", 16'd1, {15'd0, halted});
            assert (outputIndex == expectedOut.size()) else begin
                $display("ERROR: only %0d of %0d expected outputs appeared", outputIndex,
                         expectedOut.size());
                errorCount++;
            end
        end

        $display("Checks: %0d, errors: %0d", checkCount + outputChecks,
                 errorCount + outputErrors);
        if (errorCount + outputErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- tb/program_trace.txt
// Each word is kind, address and value as 2, 2 and 4 hex digits
// Kinds: 01 program word, 02 expected output in order, 03 final data word, 04 retire count
01006112 01015534 // LHI r1,0x12 / ORI r1,r1,0x34
0102F41C 01034005 // WWD r1 / ADI r0,r0,5
010443FE 0105F380 // ADI r3,r0,-2 / ADD r2,r0,r3
0106F841 0107F446 // SUB r1,r2,r0 / SHL r1,r1
0108F4C4 0109FC1C // NOT r3,r1 / WWD r3
010AF81C 010B400B // WWD r2 / ADI r0,r0,11
010C8300 010D8201 // SWD r3,0(r0) / SWD r2,1(r0)
010E7100 010FF540 // LWD r1,0(r0) / ADD r1,r1,r1 right after the load
0110F41C 01117301 // WWD r1 / LWD r3,1(r0)
0112FC1C 01138302 // WWD r3 right after the load / SWD r3,2(r0)
01140B02 01151B02 // BNE r2,r3 not taken / BEQ r2,r3 taken to 0x18
0116F01C 0117F41C // flushed by BEQ
01181201 01190202 // BEQ r0,r2 not taken / BNE r0,r2 taken to 0x1C
011AF01C 011BF01C // flushed by BNE
011C2401 011D3402 // BGZ r1 not taken / BLZ r1 taken to 0x20
011EF41C 011FF41C // flushed by BLZ
01203001 01212002 // BLZ r0 not taken / BGZ r0 taken to 0x24
0122F81C 0123F81C // flushed by BGZ
0124F01C 01259028 // WWD r0 / JMP 0x28
0126F41C 0128A02C // flushed by JMP / JAL 0x2C
0129F41C 012CF81C // flushed by JAL / WWD r2 shows link 0x29
012D4322 012EFC19 // ADI r3,r0,0x22 / JPR r3 to 0x32
012FFC1C 0130FC1C // flushed by JPR
01324027 0133F01A // ADI r0,r0,0x27 / JRL r0 to 0x37
0134F01C 0135F01C // flushed by JRL
0137F81C 01388200 // WWD r2 shows link 0x34 / SWD r2,0(r0)
0139F01D 013AF01C // HLT / behind HLT, never retires
02001234 0200FFF9 02000008 0200FFF2 // outputs in order
02000008 02000010 02000029 02000034
0310FFF9 03110008 03120008 03370034 // final data memory
04000027 // instructions retired, HLT included

//--- verilog.f
source/isaPkg.sv
source/pipePkg.sv
source/controlUnit.sv
source/registerFile.sv
source/alu.sv
source/hazardUnit.sv
source/stageLatch.sv
source/datapath.sv
source/cpuTop.sv
tb/cpuTb.sv
